// ==== src/icache_cfg_pkg.sv ====
// Instruction cache geometry
package icache_cfg_pkg;

  // Address and instruction sizes
  localparam int addr_width_c  = 32;
  localparam int instr_width_c = 32;

  // Organization
  localparam int ways_c            = 2;
  localparam int sets_c            = 16;
  localparam int words_per_block_c = 4;

  // Field widths derived from the organization
  localparam int way_sel_width_c  = $clog2(ways_c);
  localparam int index_width_c    = $clog2(sets_c);
  localparam int word_sel_width_c = $clog2(words_per_block_c);
  localparam int byte_sel_width_c = $clog2(instr_width_c / 8);

  localparam int tag_width_c =
    addr_width_c - index_width_c - word_sel_width_c - byte_sel_width_c;

  // Block address, i.e. tag and index together
  localparam int line_width_c = tag_width_c + index_width_c;

endpackage

// ==== src/icache_types_pkg.sv ====
// Instruction cache types
package icache_types_pkg;

  import icache_cfg_pkg::*;

  // Request kind on the fetch port
  typedef enum logic
  {
    e_op_fetch = 1'b0,
    e_op_fence = 1'b1
  } icache_op_e;

  // Controller states
  typedef enum logic [1:0]
  {
    e_ready = 2'd0,
    e_fill  = 2'd1,
    e_flush = 2'd2
  } icache_state_e;

  typedef logic [instr_width_c-1:0] icache_instr_t;

  // Address as seen by the tag lookup
  typedef struct packed
  {
    logic [tag_width_c-1:0]      tag;
    logic [index_width_c-1:0]    index;
    logic [word_sel_width_c-1:0] word;
    logic [byte_sel_width_c-1:0] byte_off;
  } icache_lookup_addr_s;

  // Address as seen by the block fill
  typedef struct packed
  {
    logic [line_width_c-1:0]     line;
    logic [word_sel_width_c-1:0] word;
    logic [byte_sel_width_c-1:0] byte_off;
  } icache_fill_addr_s;

  typedef union packed
  {
    icache_lookup_addr_s lookup;
    icache_fill_addr_s   fill;
  } icache_addr_u;

endpackage

// ==== src/icache_counter.sv ====
// Fill beat and flush set counter
`timescale 1ns/1ps

module icache_counter
  import icache_cfg_pkg::*;
#(
  parameter int count_width_p = index_width_c
)
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     clear_i,
  input  logic                     step_i,
  output logic [count_width_p-1:0] count_o,
  output logic                     last_o
);

  logic [count_width_p-1:0] count_r;

  // Clear wins over step
  always_ff @(posedge clk_i)
  begin
    if (reset_i || clear_i)
      count_r <= '0;
    else if (step_i)
      count_r <= count_r + 1'b1;
  end

  assign count_o = count_r;
  assign last_o  = &count_r;

endmodule

// ==== src/icache_tag_array.sv ====
// Tags, valid and LRU state
`timescale 1ns/1ps

module icache_tag_array
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       rd_en_i,
  input  icache_addr_u               rd_addr_i,
  input  logic [tag_width_c-1:0]     cmp_tag_i,
  input  logic                       install_i,
  input  logic                       flush_i,
  input  logic [index_width_c-1:0]   wr_set_i,
  input  logic [tag_width_c-1:0]     wr_tag_i,
  input  logic [way_sel_width_c-1:0] wr_way_i,
  input  logic                       lru_touch_i,
  input  logic [index_width_c-1:0]   lru_set_i,
  input  logic [way_sel_width_c-1:0] lru_way_i,
  output logic [ways_c-1:0]          hit_o,
  output logic [way_sel_width_c-1:0] victim_way_o
);

  logic [sets_c-1:0][ways_c-1:0]          valid_r;
  logic [sets_c-1:0][way_sel_width_c-1:0] lru_r;
  logic [index_width_c-1:0]               tl_set_r;
  logic [tag_width_c-1:0]                 tl_tag_r;
  logic [ways_c-1:0][tag_width_c-1:0]     rd_tag;
  logic [way_sel_width_c-1:0]             lru_way;

  for (genvar w = 0; w < ways_c; w++)
  begin : g_way
    logic [tag_width_c-1:0] tag_mem [sets_c];
    logic [tag_width_c-1:0] tag_q;

    always_ff @(posedge clk_i)
    begin
      if (install_i && (wr_way_i == way_sel_width_c'(w)))
        tag_mem[wr_set_i] <= wr_tag_i;
      if (rd_en_i)
        tag_q <= tag_mem[rd_addr_i.lookup.index];
    end

    assign rd_tag[w] = tag_q;
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_en_i)
      tl_tag_r <= cmp_tag_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid and LRU flops
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r  <= '0;
      lru_r    <= '0;
      tl_set_r <= '0;
    end
    else
    begin
      if (rd_en_i)
        tl_set_r <= rd_addr_i.lookup.index;
      if (flush_i)
      begin
        valid_r[wr_set_i] <= '0;
        lru_r[wr_set_i]   <= '0;
      end
      else if (install_i)
      begin
        valid_r[wr_set_i][wr_way_i] <= 1'b1;
        lru_r[wr_set_i]             <= ~wr_way_i;
      end
      // Point at the way not just used
      if (lru_touch_i)
        lru_r[lru_set_i] <= ~lru_way_i;
    end
  end

  // TL compare
  always_comb
  begin
    hit_o = '0;
    for (int w = 0; w < ways_c; w++)
      hit_o[w] = valid_r[tl_set_r][w] && (rd_tag[w] == tl_tag_r);
  end

  // A hit in TV on the same set lands one edge too late, so forward it
  assign lru_way = (lru_touch_i && (lru_set_i == tl_set_r)) ? ~lru_way_i : lru_r[tl_set_r];

  // Lowest invalid way first, otherwise LRU
  always_comb
  begin
    victim_way_o = lru_way;
    for (int w = ways_c - 1; w >= 0; w--)
      if (!valid_r[tl_set_r][w])
        victim_way_o = way_sel_width_c'(w);
  end

  // One tag per set at most, across all fills
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(hit_o));

endmodule

// ==== src/icache_data_array.sv ====
// Instruction block storage
`timescale 1ns/1ps

module icache_data_array
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rd_en_i,
  input  logic [index_width_c-1:0]    rd_index_i,
  input  logic [word_sel_width_c-1:0] rd_word_i,
  input  logic                        we_i,
  input  logic [way_sel_width_c-1:0]  wr_way_i,
  input  logic [index_width_c-1:0]    wr_index_i,
  input  logic [word_sel_width_c-1:0] wr_word_i,
  input  icache_instr_t               wr_data_i,
  output icache_instr_t [ways_c-1:0]  rd_data_o
);

  localparam int depth_lp = sets_c * words_per_block_c;

  // One word-addressed memory per way, set in the upper address bits
  for (genvar w = 0; w < ways_c; w++)
  begin : g_way
    icache_instr_t mem [depth_lp];
    icache_instr_t rd_q;

    always_ff @(posedge clk_i)
    begin
      if (we_i && (wr_way_i == way_sel_width_c'(w)))
        mem[{wr_index_i, wr_word_i}] <= wr_data_i;
      if (rd_en_i)
        rd_q <= mem[{rd_index_i, rd_word_i}];
    end

    assign rd_data_o[w] = rd_q;
  end

endmodule

// ==== src/icache_fetch_pipe.sv ====
// TL and TV stages of the fetch pipe
`timescale 1ns/1ps

module icache_fetch_pipe
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       accept_i,
  input  logic                       squash_i,
  input  icache_op_e                 op_i,
  input  icache_addr_u               addr_i,
  input  logic [ways_c-1:0]          hit_i,
  input  logic [way_sel_width_c-1:0] victim_way_i,
  input  icache_instr_t [ways_c-1:0] way_data_i,
  output logic                       tv_miss_o,
  output logic                       tv_fence_o,
  output logic [line_width_c-1:0]    miss_line_o,
  output logic [way_sel_width_c-1:0] victim_way_o,
  output icache_instr_t              data_o,
  output logic                       data_v_o,
  output logic                       miss_v_o
);

  logic                       tl_v_r;
  icache_op_e                 tl_op_r;
  logic [line_width_c-1:0]    tl_line_r;
  logic                       tv_v_r;
  icache_op_e                 tv_op_r;
  logic                       tv_hit_r;
  logic [line_width_c-1:0]    tv_line_r;
  logic [way_sel_width_c-1:0] tv_way_r;
  icache_instr_t              tv_data_r;
  icache_instr_t              hit_word;
  logic [way_sel_width_c-1:0] hit_way;
  logic                       tv_fetch;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tl_v_r <= 1'b0;
      tv_v_r <= 1'b0;
    end
    else
    begin
      tl_v_r <= accept_i;
      tv_v_r <= tl_v_r && !squash_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept_i)
    begin
      tl_op_r   <= op_i;
      tl_line_r <= addr_i.fill.line;
    end
  end

  // Way select by hit vector
  always_comb
  begin
    hit_word = way_data_i[0];
    hit_way  = '0;
    for (int w = 0; w < ways_c; w++)
      if (hit_i[w])
      begin
        hit_word = way_data_i[w];
        hit_way  = way_sel_width_c'(w);
      end
  end

  // TV holds its last entry so the miss line stays put
  always_ff @(posedge clk_i)
  begin
    if (tl_v_r)
    begin
      tv_op_r   <= tl_op_r;
      tv_hit_r  <= |hit_i;
      tv_line_r <= tl_line_r;
      // Hit way feeds the LRU touch, victim feeds the fill
      tv_way_r  <= (|hit_i) ? hit_way : victim_way_i;
      tv_data_r <= hit_word;
    end
  end

  assign tv_fetch = tv_v_r && (tv_op_r == e_op_fetch);

  assign data_o       = tv_data_r;
  assign data_v_o     = tv_fetch && tv_hit_r;
  assign miss_v_o     = tv_fetch && !tv_hit_r;
  assign tv_miss_o    = miss_v_o;
  assign tv_fence_o   = tv_v_r && (tv_op_r == e_op_fence);
  assign miss_line_o  = tv_line_r;
  assign victim_way_o = tv_way_r;

endmodule

// ==== src/icache_ctrl_fsm.sv ====
// Cache controller for fill and flush
`timescale 1ns/1ps

module icache_ctrl_fsm
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        v_i,
  input  icache_op_e                  op_i,
  input  logic                        tv_miss_i,
  input  logic                        tv_fence_i,
  input  logic [line_width_c-1:0]     miss_line_i,
  input  logic [way_sel_width_c-1:0]  victim_way_i,
  input  logic                        mem_ack_i,
  input  logic [index_width_c-1:0]    count_i,
  input  logic                        count_last_i,
  output logic                        ready_o,
  output logic                        accept_o,
  output logic                        squash_o,
  output logic                        mem_req_o,
  output icache_addr_u                mem_addr_o,
  output logic                        count_clear_o,
  output logic                        count_step_o,
  output logic                        fill_we_o,
  output logic [way_sel_width_c-1:0]  fill_way_o,
  output logic [word_sel_width_c-1:0] fill_word_o,
  output logic                        install_o,
  output logic                        flush_o
);

  icache_state_e               state_r;
  icache_state_e               state_n;
  logic                        req_r;
  logic                        req_n;
  logic                        tl_fence_r;
  logic                        fence_pend_r;
  logic [line_width_c-1:0]     line_r;
  logic [way_sel_width_c-1:0]  way_r;
  logic                        beat_done;
  logic                        fill_done;

  // Pipe stops taking requests while a miss or fence sits in TV
  assign ready_o  = (state_r == e_ready) && !tv_miss_i && !tv_fence_i;
  assign accept_o = v_i && ready_o;
  assign squash_o = tv_miss_i || tv_fence_i;

  assign beat_done = req_r && mem_ack_i;
  // Counter bit above the beat number is set after four beats
  assign fill_done = count_i[word_sel_width_c];

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_n      = state_r;
    req_n        = req_r;
    count_step_o = 1'b0;
    fill_we_o    = 1'b0;
    install_o    = 1'b0;
    flush_o      = 1'b0;
    case (state_r)
      e_ready:
      begin
        if (tv_miss_i)
          state_n = e_fill;
        else if (tv_fence_i)
          state_n = e_flush;
      end
      e_fill:
      begin
        if (beat_done)
        begin
          // Word captured, drop the request
          req_n        = 1'b0;
          fill_we_o    = 1'b1;
          count_step_o = 1'b1;
          install_o    = &count_i[word_sel_width_c-1:0];
        end
        else if (!req_r && !mem_ack_i)
        begin
          if (fill_done)
            state_n = fence_pend_r ? e_flush : e_ready;
          else
            req_n = 1'b1;
        end
      end
      e_flush:
      begin
        flush_o      = 1'b1;
        count_step_o = 1'b1;
        if (count_last_i)
          state_n = e_ready;
      end
      default:
        state_n = e_ready;
    endcase
  end

  // Counter restarts on every state change
  assign count_clear_o = (state_n != state_r);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r      <= e_ready;
      req_r        <= 1'b0;
      tl_fence_r   <= 1'b0;
      fence_pend_r <= 1'b0;
    end
    else
    begin
      state_r    <= state_n;
      req_r      <= req_n;
      tl_fence_r <= accept_o && (op_i == e_op_fence);
      // A fence squashed behind a miss runs once the fill is over
      if ((state_r == e_ready) && tv_miss_i && tl_fence_r)
        fence_pend_r <= 1'b1;
      else if (state_n == e_flush)
        fence_pend_r <= 1'b0;
    end
  end

  // Missed block and its replacement way
  always_ff @(posedge clk_i)
  begin
    if ((state_r == e_ready) && tv_miss_i)
    begin
      line_r <= miss_line_i;
      way_r  <= victim_way_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory port and array write control
  ////////////////////////////////////////////////////////////////////////////
  assign mem_req_o   = req_r;
  assign fill_way_o  = way_r;
  assign fill_word_o = count_i[word_sel_width_c-1:0];

  // Flush sweeps the set field, fill walks the words of the missed line
  always_comb
  begin
    mem_addr_o = '0;
    if (state_r == e_flush)
      mem_addr_o.lookup.index = count_i;
    else
    begin
      mem_addr_o.fill.line = line_r;
      mem_addr_o.fill.word = count_i[word_sel_width_c-1:0];
    end
  end

  // Four-phase rule on the memory side
  a_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o && !mem_ack_i |=> mem_req_o);

  a_req_in_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o |-> (state_r == e_fill));

endmodule

// ==== src/icache_top.sv ====
// Instruction cache top level
`timescale 1ns/1ps

module icache_top
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,

  // Fetch request
  input  icache_op_e    op_i,
  input  icache_addr_u  addr_i,
  input  logic          v_i,
  output logic          ready_o,

  // Fetch result
  output icache_instr_t data_o,
  output logic          data_v_o,
  output logic          miss_v_o,

  // Fill memory port
  output logic          mem_req_o,
  output icache_addr_u  mem_addr_o,
  input  logic          mem_ack_i,
  input  icache_instr_t mem_data_i
);

  logic                        accept;
  logic                        squash;
  logic                        tv_miss;
  logic                        tv_fence;
  logic [line_width_c-1:0]     miss_line;
  logic [way_sel_width_c-1:0]  tv_way;
  logic [way_sel_width_c-1:0]  tl_victim;
  logic [ways_c-1:0]           tl_hit;
  icache_instr_t [ways_c-1:0]  tl_way_data;
  logic [index_width_c-1:0]    count;
  logic                        count_last;
  logic                        count_clear;
  logic                        count_step;
  logic                        fill_we;
  logic [way_sel_width_c-1:0]  fill_way;
  logic [word_sel_width_c-1:0] fill_word;
  logic                        install;
  logic                        flush;

  icache_ctrl_fsm i_ctrl_fsm (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(v_i), .op_i(op_i),
    .tv_miss_i(tv_miss), .tv_fence_i(tv_fence),
    .miss_line_i(miss_line), .victim_way_i(tv_way),
    .mem_ack_i(mem_ack_i),
    .count_i(count), .count_last_i(count_last),
    .ready_o(ready_o), .accept_o(accept), .squash_o(squash),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
    .count_clear_o(count_clear), .count_step_o(count_step),
    .fill_we_o(fill_we), .fill_way_o(fill_way), .fill_word_o(fill_word),
    .install_o(install), .flush_o(flush)
  );

  icache_counter #(.count_width_p(index_width_c)) i_counter (
    .clk_i(clk_i), .reset_i(reset_i),
    .clear_i(count_clear), .step_i(count_step),
    .count_o(count), .last_o(count_last)
  );

  icache_fetch_pipe i_fetch_pipe (
    .clk_i(clk_i), .reset_i(reset_i),
    .accept_i(accept), .squash_i(squash),
    .op_i(op_i), .addr_i(addr_i),
    .hit_i(tl_hit), .victim_way_i(tl_victim), .way_data_i(tl_way_data),
    .tv_miss_o(tv_miss), .tv_fence_o(tv_fence),
    .miss_line_o(miss_line), .victim_way_o(tv_way),
    .data_o(data_o), .data_v_o(data_v_o), .miss_v_o(miss_v_o)
  );

  // Fill and flush both address the tag and data arrays through the lookup view
  icache_tag_array i_tag_array (
    .clk_i(clk_i), .reset_i(reset_i),
    .rd_en_i(accept), .rd_addr_i(addr_i), .cmp_tag_i(addr_i.lookup.tag),
    .install_i(install), .flush_i(flush),
    .wr_set_i(mem_addr_o.lookup.index), .wr_tag_i(mem_addr_o.lookup.tag),
    .wr_way_i(fill_way),
    .lru_touch_i(data_v_o), .lru_set_i(miss_line[index_width_c-1:0]),
    .lru_way_i(tv_way),
    .hit_o(tl_hit), .victim_way_o(tl_victim)
  );

  icache_data_array i_data_array (
    .clk_i(clk_i),
    .rd_en_i(accept), .rd_index_i(addr_i.lookup.index), .rd_word_i(addr_i.lookup.word),
    .we_i(fill_we), .wr_way_i(fill_way),
    .wr_index_i(mem_addr_o.lookup.index), .wr_word_i(fill_word),
    .wr_data_i(mem_data_i),
    .rd_data_o(tl_way_data)
  );

endmodule

// ==== test/icache_mem_model.sv ====
// Four-phase fill memory responder
`timescale 1ns/1ps

module icache_mem_model
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          req_i,
  input  icache_addr_u  addr_i,
  output logic          ack_o,
  output icache_instr_t data_o
);

  int seed;
  int delay;

  // Each word reads back as its word address XOR a fixed pattern
  initial
  begin
    seed   = 32'h6f00576a;
    ack_o  = 1'b0;
    data_o = '0;
    forever
    begin
      @(negedge clk_i);
      if (!reset_i && req_i)
      begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        ack_o  <= 1'b1;
        data_o <= {2'b00, addr_i.fill.line, addr_i.fill.word} ^ 32'h1234abcd;
        // Hold ack until the cache lets go of the request
        @(negedge clk_i);
        while (req_i)
          @(negedge clk_i);
        @(posedge clk_i);
        ack_o <= 1'b0;
      end
    end
  end

endmodule

// ==== test/icache_tb.sv ====
// Instruction cache testbench
`timescale 1ns/1ps

module icache_tb
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
;

  logic          clk_i;
  logic          reset_i;
  icache_op_e    op_i;
  icache_addr_u  addr_i;
  logic          v_i;
  logic          ready_o;
  icache_instr_t data_o;
  logic          data_v_o;
  logic          miss_v_o;
  logic          mem_req_o;
  icache_addr_u  mem_addr_o;
  logic          mem_ack_i;
  icache_instr_t mem_data_i;

  // Stimulus table
  string        tbl_name [$];
  icache_op_e   tbl_op   [$];
  icache_addr_u tbl_addr [$];
  logic         tbl_b2b  [$];

  // Expected results and fill requests, in order
  logic          exp_hit_q  [$];
  icache_instr_t exp_data_q [$];
  string         exp_name_q [$];
  icache_addr_u  exp_addr_q [$];
  string         addr_name_q [$];
  int            replay_q [$];

  // Reference model state
  logic [ways_c-1:0]          m_valid [sets_c];
  logic [tag_width_c-1:0]     m_tag   [sets_c][ways_c];
  logic [way_sel_width_c-1:0] m_lru   [sets_c];
  logic                       prev_miss;
  logic                       prev_fence;

  logic ready_seen;
  logic req_seen;
  logic acc_d1;
  logic acc_d2;
  icache_addr_u held_addr;

  int data_errs;
  int kind_errs;
  int addr_errs;
  int other_errs;
  int cycle_cnt;
  int cycle_limit;

  icache_top i_icache_top (
    .clk_i(clk_i), .reset_i(reset_i),
    .op_i(op_i), .addr_i(addr_i), .v_i(v_i), .ready_o(ready_o),
    .data_o(data_o), .data_v_o(data_v_o), .miss_v_o(miss_v_o),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
    .mem_ack_i(mem_ack_i), .mem_data_i(mem_data_i)
  );

  icache_mem_model i_mem_model (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_i(mem_req_o), .addr_i(mem_addr_o),
    .ack_o(mem_ack_i), .data_o(mem_data_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
      #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_instr(input string name, input icache_instr_t exp,
                             input icache_instr_t act);
    if (exp !== act)
    begin
      data_errs++;
      $display("ERR %s: data expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_kind(input string name, input logic exp_hit, input logic act_hit);
    if (exp_hit !== act_hit)
    begin
      kind_errs++;
      $display("ERR %s: result expected %s, actual %s", name,
               exp_hit ? "hit" : "miss", act_hit ? "hit" : "miss");
    end
  endtask

  task automatic check_addr(input string name, input icache_addr_u exp,
                            input icache_addr_u act);
    if (exp !== act)
    begin
      addr_errs++;
      $display("ERR %s: memory address expected %h, actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic icache_instr_t mem_word(input icache_addr_u a);
    return {2'b00, a.fill.line, a.fill.word} ^ 32'h1234abcd;
  endfunction

  function automatic void model_flush();
    for (int s = 0; s < sets_c; s++)
    begin
      m_valid[s] = '0;
      m_lru[s]   = '0;
    end
  endfunction

  // Returns the hit flag; a miss installs the line as the fill will
  function automatic logic model_access(input icache_addr_u a);
    logic [index_width_c-1:0]   set;
    logic [way_sel_width_c-1:0] way;
    logic                       hit;
    set = a.lookup.index;
    hit = 1'b0;
    way = '0;
    for (int w = 0; w < ways_c; w++)
      if (m_valid[set][w] && (m_tag[set][w] == a.lookup.tag))
      begin
        hit = 1'b1;
        way = way_sel_width_c'(w);
      end
    if (!hit)
    begin
      if (!m_valid[set][0])
        way = '0;
      else if (!m_valid[set][1])
        way = 1'b1;
      else
        way = m_lru[set];
      m_valid[set][way] = 1'b1;
      m_tag[set][way]   = a.lookup.tag;
    end
    m_lru[set] = ~way;
    return hit;
  endfunction

  task automatic add_entry(input string name, input icache_op_e op,
                           input logic [tag_width_c-1:0] tag,
                           input logic [index_width_c-1:0] index,
                           input logic [word_sel_width_c-1:0] word, input logic b2b);
    icache_addr_u a;
    a                 = '0;
    a.lookup.tag      = tag;
    a.lookup.index    = index;
    a.lookup.word     = word;
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_addr.push_back(a);
    tbl_b2b.push_back(b2b);
  endtask

  task automatic build_table();
    // Cold misses and fills
    add_entry("cold_line1",   e_op_fetch, 24'h000100, 4'd1, 2'd0, 1'b0);
    add_entry("cold_line2",   e_op_fetch, 24'h000100, 4'd2, 2'd3, 1'b0);
    add_entry("filled_word",  e_op_fetch, 24'h000100, 4'd1, 2'd1, 1'b0);
    // Back-to-back hits, then a fetch right behind a miss
    add_entry("b2b_a",        e_op_fetch, 24'h000100, 4'd1, 2'd2, 1'b0);
    add_entry("b2b_b",        e_op_fetch, 24'h000100, 4'd2, 2'd0, 1'b1);
    add_entry("b2b_c",        e_op_fetch, 24'h000100, 4'd1, 2'd3, 1'b1);
    add_entry("b2b_d",        e_op_fetch, 24'h000100, 4'd2, 2'd1, 1'b1);
    add_entry("miss_ahead",   e_op_fetch, 24'h000200, 4'd3, 2'd0, 1'b0);
    add_entry("squashed",     e_op_fetch, 24'h000100, 4'd1, 2'd0, 1'b1);
    // Three lines in set 5
    add_entry("lru_a",        e_op_fetch, 24'h000010, 4'd5, 2'd0, 1'b0);
    add_entry("lru_b",        e_op_fetch, 24'h000020, 4'd5, 2'd1, 1'b0);
    add_entry("lru_touch_a",  e_op_fetch, 24'h000010, 4'd5, 2'd2, 1'b0);
    add_entry("lru_c",        e_op_fetch, 24'h000030, 4'd5, 2'd3, 1'b0);
    add_entry("lru_keep_a",   e_op_fetch, 24'h000010, 4'd5, 2'd1, 1'b0);
    add_entry("lru_lost_b",   e_op_fetch, 24'h000020, 4'd5, 2'd0, 1'b0);
    // Fence with a fetch ahead of it
    add_entry("pre_fence",    e_op_fetch, 24'h000100, 4'd2, 2'd2, 1'b0);
    add_entry("fence",        e_op_fence, 24'h000000, 4'd0, 2'd0, 1'b1);
    add_entry("post_fence_1", e_op_fetch, 24'h000100, 4'd1, 2'd0, 1'b0);
    add_entry("post_fence_2", e_op_fetch, 24'h000100, 4'd2, 2'd2, 1'b0);
    add_entry("post_fence_5", e_op_fetch, 24'h000010, 4'd5, 2'd0, 1'b0);
    add_entry("refill_hit",   e_op_fetch, 24'h000100, 4'd1, 2'd3, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////////////////////
  // Holds the request until ready_o lets it in; returns on the accepting edge
  task automatic issue(input int idx, input logic b2b, output logic immediate);
    int waits;
    waits = 0;
    op_i   <= tbl_op[idx];
    addr_i <= tbl_addr[idx];
    v_i    <= 1'b1;
    @(negedge clk_i);
    while (!ready_o)
    begin
      waits++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    immediate = b2b && (waits == 0);
  endtask

  task automatic apply_entry(input int idx, input logic b2b);
    logic         immediate;
    logic         is_fence;
    logic         hit;
    icache_addr_u a;
    issue(idx, b2b, immediate);
    is_fence = (tbl_op[idx] == e_op_fence);
    a        = tbl_addr[idx];
    if (immediate && (prev_miss || prev_fence))
    begin
      // Squashed in TL; a fence behind a miss still runs after the fill
      if (is_fence && prev_miss)
        model_flush();
      else if (!is_fence)
        replay_q.push_back(idx);
      prev_miss  = 1'b0;
      prev_fence = 1'b0;
    end
    else if (is_fence)
    begin
      model_flush();
      prev_miss  = 1'b0;
      prev_fence = 1'b1;
    end
    else
    begin
      hit = model_access(a);
      exp_hit_q.push_back(hit);
      exp_data_q.push_back(mem_word(a));
      exp_name_q.push_back(tbl_name[idx]);
      if (!hit)
      begin
        for (int w = 0; w < words_per_block_c; w++)
        begin
          a.fill.word = word_sel_width_c'(w);
          exp_addr_q.push_back(a);
          addr_name_q.push_back(tbl_name[idx]);
        end
        replay_q.push_back(idx);
      end
      prev_miss  = !hit;
      prev_fence = 1'b0;
    end
  endtask

  task automatic wait_idle();
    @(posedge clk_i);
    while ((exp_hit_q.size() != 0) || (exp_addr_q.size() != 0) || !ready_seen)
      @(posedge clk_i);
  endtask

  task automatic drain_replays();
    int idx;
    while (replay_q.size() != 0)
    begin
      idx = replay_q.pop_front();
      apply_entry(idx, 1'b0);
      v_i <= 1'b0;
      wait_idle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result and memory port monitor
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk_i)
  begin : monitor
    logic          exp_hit;
    icache_instr_t exp_data;
    string         name;
    ready_seen = ready_o;
    if (!reset_i)
    begin
      if (data_v_o && miss_v_o)
      begin
        other_errs++;
        $display("data_v_o and miss_v_o are high in the same cycle");
      end
      else if (data_v_o || miss_v_o)
      begin
        if (!acc_d2)
        begin
          other_errs++;
          $display("result did not come two edges after an accepted request");
        end
        if (exp_hit_q.size() == 0)
        begin
          other_errs++;
          $display("result appeared with no fetch outstanding");
        end
        else
        begin
          exp_hit  = exp_hit_q.pop_front();
          exp_data = exp_data_q.pop_front();
          name     = exp_name_q.pop_front();
          check_kind(name, exp_hit, data_v_o);
          if (exp_hit && data_v_o)
            check_instr(name, exp_data, data_o);
        end
      end
      // New memory beat
      if (mem_req_o && !req_seen)
      begin
        if (exp_addr_q.size() == 0)
        begin
          other_errs++;
          $display("memory request %h with no fill expected", mem_addr_o);
        end
        else
          check_addr(addr_name_q.pop_front(), exp_addr_q.pop_front(), mem_addr_o);
      end
      else if (mem_req_o && (mem_addr_o !== held_addr))
      begin
        other_errs++;
        $display("memory address changed while the request was up");
      end
    end
    req_seen  = mem_req_o;
    held_addr = mem_addr_o;
    acc_d2    = acc_d1;
    acc_d1    = v_i && ready_o;
  end

  initial
  begin : watchdog
    @(posedge clk_i);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

  initial
  begin : main
    int total;
    reset_i    = 1'b1;
    v_i        = 1'b0;
    op_i       = e_op_fetch;
    addr_i     = '0;
    prev_miss  = 1'b0;
    prev_fence = 1'b0;
    ready_seen = 1'b0;
    req_seen   = 1'b0;
    acc_d1     = 1'b0;
    acc_d2     = 1'b0;
    held_addr  = '0;
    data_errs  = 0;
    kind_errs  = 0;
    addr_errs  = 0;
    other_errs = 0;
    cycle_cnt  = 0;
    build_table();
    cycle_limit = tbl_addr.size() * 40;
    model_flush();

    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (!ready_o || data_v_o || miss_v_o || mem_req_o)
    begin
      other_errs++;
      $display("outputs not in their reset state after reset");
    end
    @(posedge clk_i);

    for (int i = 0; i < tbl_addr.size(); i++)
    begin
      if (!tbl_b2b[i])
      begin
        v_i <= 1'b0;
        wait_idle();
        drain_replays();
      end
      apply_entry(i, tbl_b2b[i]);
    end
    v_i <= 1'b0;
    wait_idle();
    drain_replays();

    total = data_errs + kind_errs + addr_errs + other_errs;
    $display("errors: data %0d, kind %0d, address %0d, other %0d",
             data_errs, kind_errs, addr_errs, other_errs);
    if (total == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
src/icache_cfg_pkg.sv
src/icache_types_pkg.sv
src/icache_counter.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_fetch_pipe.sv
src/icache_ctrl_fsm.sv
src/icache_top.sv
test/icache_mem_model.sv
test/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv -f filelist.f \
  --top-module icache_tb -Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0
